//--- Makefile
# Verilator build and run of the return address prediction testbench

VERILATOR ?= verilator
TOP ?= tb_fetch_predict
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/fetch_if.sv
/* Valid/ready channel for classified instructions, used between predecode,
   the fetch queue and the return predictor */
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

	// Handshake, a transfer happens on a clock edge with both high
	logic valid;
	logic ready;

	// Payload, held stable by the source while valid waits for ready
	fetch_pkg::pc_address_t pc;
	fetch_pkg::instruction_t insn;
	fetch_pkg::insn_kind_t kind;

	// Side that offers instructions
	modport source (
		output valid,
		output pc,
		output insn,
		output kind,
		input ready
	);

	// Side that takes instructions
	modport sink (
		input valid,
		input pc,
		input insn,
		input kind,
		output ready
	);

endinterface

`default_nettype wire

//--- design/fetch_pkg.sv
/* Instruction fetch types and opcode constants shared by the predecoder,
   the fetch queue and the return predictor */
`default_nettype none

package fetch_pkg;

	// ========================================================================
	// Address and instruction widths
	// ========================================================================

	// Byte address of a fetched instruction
	typedef logic [43:0] pc_address_t;

	// One complete instruction word, all instructions are five bytes
	typedef logic [39:0] instruction_t;

	// Opcode field taken from the low bits of the instruction word
	typedef logic [6:0] opcode_t;

	// Classification made by predecode and carried along with every word
	typedef enum logic [1:0] {
		KIND_OTHER = 2'd0,
		KIND_CALL  = 2'd1,
		KIND_RET   = 2'd2
	} insn_kind_t;

	// Opcode values that identify subroutine linkage
	localparam opcode_t CALL_OPCODE = 7'h54;
	localparam opcode_t RET_OPCODE  = 7'h55;

	// A call returns to the instruction right after it
	localparam int INSN_BYTES = 5;

	// ========================================================================
	// Fetch queue sizing
	// ========================================================================
	localparam int FETCH_QUEUE_DEPTH = 4;
	localparam int FETCH_QUEUE_PTR_W = $clog2(FETCH_QUEUE_DEPTH);

	// Pointers wrap on their own since the depth is a power of two
	typedef logic [FETCH_QUEUE_PTR_W-1:0] fq_ptr_t;
	// Occupancy needs one extra bit to tell full from empty
	typedef logic [FETCH_QUEUE_PTR_W:0] fq_count_t;

endpackage

`default_nettype wire

//--- design/fetch_predict_top.sv
/* Return address prediction path. Predecode, fetch queue and return
   predictor in a chain, with valid/ready ports on both ends */
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	output logic in_ready,
	input fetch_pkg::pc_address_t in_pc,
	input fetch_pkg::instruction_t in_insn,
	output logic out_valid,
	input wire logic out_ready,
	output fetch_pkg::pc_address_t out_pc,
	output fetch_pkg::insn_kind_t out_kind,
	output fetch_pkg::pc_address_t out_target
);

	// ========================================================================
	// Internal channels
	// ========================================================================

	// Predecode to queue
	fetch_if pre_q ();
	// Queue to predictor
	fetch_if q_pred ();

	ifetch_predecode u_predecode (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pc(in_pc),
		.in_insn(in_insn),
		.q(pre_q.source)
	);

	fetch_queue u_fetch_queue (
		.clk(clk),
		.rst(rst),
		.wr(pre_q.sink),
		.rd(q_pred.source)
	);

	return_predictor u_return_predictor (
		.clk(clk),
		.rst(rst),
		.q(q_pred.sink),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_pc(out_pc),
		.out_kind(out_kind),
		.out_target(out_target)
	);

endmodule

`default_nettype wire

//--- design/fetch_queue.sv
/* Small circular FIFO that decouples predecode from return prediction.
   Written on the sink side, the head is offered on the source side */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
	input wire logic clk,
	input wire logic rst,
	fetch_if.sink wr,
	fetch_if.source rd
);

	// ========================================================================
	// Storage, payload only so no reset is applied
	// ========================================================================
	fetch_pkg::pc_address_t pc_mem [fetch_pkg::FETCH_QUEUE_DEPTH];
	fetch_pkg::instruction_t insn_mem [fetch_pkg::FETCH_QUEUE_DEPTH];
	fetch_pkg::insn_kind_t kind_mem [fetch_pkg::FETCH_QUEUE_DEPTH];

	// ========================================================================
	// Pointers and occupancy
	// ========================================================================
	fetch_pkg::fq_ptr_t wr_ptr;
	fetch_pkg::fq_ptr_t rd_ptr;
	fetch_pkg::fq_count_t count;
	logic do_wr;
	logic do_rd;

	// Both flags depend on the count and nothing else, which keeps
	// ready free of any path from the downstream ready
	assign wr.ready = (count != fetch_pkg::fq_count_t'(fetch_pkg::FETCH_QUEUE_DEPTH));
	assign rd.valid = (count != '0);

	assign do_wr = wr.valid && wr.ready;
	assign do_rd = rd.valid && rd.ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// A write and a read together leave the count where it is
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			pc_mem[wr_ptr] <= wr.pc;
			insn_mem[wr_ptr] <= wr.insn;
			kind_mem[wr_ptr] <= wr.kind;
		end
	end

	// Head of the queue is visible the cycle after it was written
	assign rd.pc = pc_mem[rd_ptr];
	assign rd.insn = insn_mem[rd_ptr];
	assign rd.kind = kind_mem[rd_ptr];

endmodule

`default_nettype wire

//--- design/ifetch_predecode.sv
/* First fetch stage. Registers each incoming instruction word and tags it as
   call, return or other from its opcode before handing it on */
`timescale 1ns/1ps
`default_nettype none

module ifetch_predecode (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	output logic in_ready,
	input fetch_pkg::pc_address_t in_pc,
	input fetch_pkg::instruction_t in_insn,
	fetch_if.source q
);

	// ========================================================================
	// Opcode classification
	// ========================================================================
	fetch_pkg::opcode_t opcode;
	fetch_pkg::insn_kind_t kind_next;

	// The opcode sits in the lowest bits of the word
	assign opcode = in_insn[6:0];

	always_comb begin
		if (opcode == fetch_pkg::CALL_OPCODE)
			kind_next = fetch_pkg::KIND_CALL;
		else if (opcode == fetch_pkg::RET_OPCODE)
			kind_next = fetch_pkg::KIND_RET;
		else
			kind_next = fetch_pkg::KIND_OTHER;
	end

	// ========================================================================
	// One-entry pipeline register
	// ========================================================================
	logic full;
	fetch_pkg::pc_address_t pc_r;
	fetch_pkg::instruction_t insn_r;
	fetch_pkg::insn_kind_t kind_r;
	logic accept;

	// Room is available when empty, or when the held word leaves this cycle
	assign in_ready = !full || q.ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			full <= 1'b0;
		else if (accept)
			full <= 1'b1;
		else if (q.ready)
			full <= 1'b0;
	end

	// Payload only changes on acceptance, so it stays stable while stalled
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_r <= in_pc;
			insn_r <= in_insn;
			kind_r <= kind_next;
		end
	end

	assign q.valid = full;
	assign q.pc = pc_r;
	assign q.insn = insn_r;
	assign q.kind = kind_r;

endmodule

`default_nettype wire

//--- design/return_predictor.sv
/* Consumer stage. Takes classified instructions from the fetch queue, keeps
   the return stack up to date and presents each item with its predicted target */
`timescale 1ns/1ps
`default_nettype none

module return_predictor (
	input wire logic clk,
	input wire logic rst,
	fetch_if.sink q,
	output logic out_valid,
	input wire logic out_ready,
	output fetch_pkg::pc_address_t out_pc,
	output fetch_pkg::insn_kind_t out_kind,
	output fetch_pkg::pc_address_t out_target
);

	// ========================================================================
	// Acceptance and stack strobes
	// ========================================================================
	logic accept;
	logic push;
	logic pop;
	fetch_pkg::pc_address_t ret_addr;
	fetch_pkg::pc_address_t tos;

	// The output register is free when empty or being taken this cycle
	assign q.ready = !out_valid || out_ready;
	assign accept = q.valid && q.ready;

	// Exactly one strobe per accepted call or return, never both
	assign push = accept && (q.kind == fetch_pkg::KIND_CALL);
	assign pop = accept && (q.kind == fetch_pkg::KIND_RET);

	// Return address is the instruction following the call
	assign ret_addr = q.pc + fetch_pkg::pc_address_t'(fetch_pkg::INSN_BYTES);

	return_stack u_return_stack (
		.clk(clk),
		.rst(rst),
		.push(push),
		.pop(pop),
		.pc(ret_addr),
		.o(tos)
	);

	// ========================================================================
	// Output register
	// ========================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// The top is sampled on the same edge as the pop, so a return sees
	// the address its matching call pushed. Other kinds just carry the top
	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc <= q.pc;
			out_kind <= q.kind;
			out_target <= tos;
		end
	end

endmodule

`default_nettype wire

//--- design/return_stack.sv
/* Circular return stack buffer. A push stores a return address below the
   pointer, a pop moves the pointer up, and the top entry is always shown */
`timescale 1ns/1ps
`default_nettype none

module return_stack (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire logic pop,
	input fetch_pkg::pc_address_t pc,
	output fetch_pkg::pc_address_t o
);

	// ========================================================================
	// Stack storage and pointer
	// ========================================================================
	fetch_pkg::pc_address_t stack [rsb_pkg::RSB_DEPTH];
	rsb_pkg::rsb_ptr_t sp;
	rsb_pkg::rsb_ptr_t push_idx;

	// The stack grows downward, a push lands one below the current top.
	// Wrapping past zero overwrites the oldest return address
	assign push_idx = sp - 1'b1;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sp <= '0;
			// Entries are reset too, so an empty stack predicts a known address
			for (int i = 0; i < rsb_pkg::RSB_DEPTH; i++)
				stack[i] <= rsb_pkg::RSB_RESET_ADDR;
		end
		else begin
			// Push and pop together cancel out on the pointer
			if (push && !pop)
				sp <= push_idx;
			else if (pop && !push)
				sp <= sp + 1'b1;
			if (push)
				stack[push_idx] <= pc;
		end
	end

	// Top of stack, before any update on this edge
	assign o = stack[sp];

endmodule

`default_nettype wire

//--- design/rsb_pkg.sv
/* Sizing and reset contents of the return stack buffer used by the
   return address predictor */
`default_nettype none

package rsb_pkg;

	// ========================================================================
	// Return stack buffer geometry
	// ========================================================================

	// Number of return addresses kept before the oldest is overwritten
	localparam int RSB_DEPTH = 64;

	// Stack pointer, arithmetic on it wraps modulo the depth
	typedef logic [$clog2(RSB_DEPTH)-1:0] rsb_ptr_t;

	// Every entry holds this address after reset, so an unmatched return
	// predicts a fixed, recognizable target
	localparam fetch_pkg::pc_address_t RSB_RESET_ADDR = 44'hFFFD0000000;

endpackage

`default_nettype wire

//--- tb/fetch_predict_assertions.sv
/* Handshake and stack strobe checks, bound into the fetch queue and the
   return predictor of the prediction path */
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_assertions (
	input wire logic clk,
	input wire logic rst,
	input wire logic valid,
	input wire logic ready,
	input fetch_pkg::pc_address_t data,
	input fetch_pkg::fq_count_t level,
	input wire logic push,
	input wire logic pop
);

	// ========================================================================
	// Valid/ready channel rules
	// ========================================================================

	// An offered item stays offered and unchanged until it is taken
	property valid_held_until_ready;
		@(posedge clk) disable iff (rst)
		valid && !ready |=> valid && $stable(data);
	endproperty

	assert property (valid_held_until_ready)
		else $error("valid dropped or data changed before ready");

	// The queue occupancy never goes past its depth
	property level_within_depth;
		@(posedge clk) disable iff (rst)
		level <= fetch_pkg::fq_count_t'(fetch_pkg::FETCH_QUEUE_DEPTH);
	endproperty

	assert property (level_within_depth)
		else $error("fetch queue occupancy above its depth");

	// ========================================================================
	// Return stack strobes
	// ========================================================================

	// An accepted item is a call or a return but never both
	property single_stack_strobe;
		@(posedge clk) disable iff (rst)
		!(push && pop);
	endproperty

	assert property (single_stack_strobe)
		else $error("push and pop asserted in the same cycle");

endmodule

// The queue's read side must keep its head entry stable while it waits
bind fetch_queue fetch_predict_assertions u_queue_assertions (
	.clk(clk),
	.rst(rst),
	.valid(rd.valid),
	.ready(rd.ready),
	.data(rd.pc),
	.level(count),
	.push(1'b0),
	.pop(1'b0)
);

// The predictor's output register and its stack strobes
bind return_predictor fetch_predict_assertions u_predictor_assertions (
	.clk(clk),
	.rst(rst),
	.valid(out_valid),
	.ready(out_ready),
	.data(out_pc),
	.level('0),
	.push(push),
	.pop(pop)
);

`default_nettype wire

//--- tb/tb_fetch_predict.sv
/* Testbench for the return address prediction path. Runs a call/return
   table and a deep nesting loop against a model stack under back-pressure */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_predict;

	// ========================================================================
	// Stimulus sizes, table and limits
	// ========================================================================
	localparam int TABLE_ROWS = 14;
	localparam int NEST_DEPTH = 66;
	localparam int TOTAL_ITEMS = TABLE_ROWS + 2 * NEST_DEPTH;
	localparam int TIMEOUT_CYCLES = 20 * TOTAL_ITEMS + 100;
	// Any opcode that is neither a call nor a return
	localparam fetch_pkg::opcode_t OTHER_OPCODE = 7'h13;
	localparam fetch_pkg::pc_address_t NEST_CALL_BASE = 44'h0A0_0000_0000;
	localparam fetch_pkg::pc_address_t NEST_RET_BASE = 44'h0B0_0000_0000;

	// Two unmatched returns first, then nested calls with other words between
	fetch_pkg::pc_address_t table_pc [TABLE_ROWS] = '{
		44'h000_0010_0000, 44'h000_0010_0040, 44'h000_0020_0000,
		44'h000_0020_0005, 44'h000_0020_000A, 44'h000_0030_0000,
		44'h000_0030_0005, 44'h000_0040_0000, 44'h000_0041_0000,
		44'h000_0031_0000, 44'h000_0031_0005, 44'h000_0050_0000,
		44'h000_0051_0000, 44'h000_0021_0000
	};
	fetch_pkg::insn_kind_t table_kind [TABLE_ROWS] = '{
		fetch_pkg::KIND_RET, fetch_pkg::KIND_RET, fetch_pkg::KIND_CALL,
		fetch_pkg::KIND_OTHER, fetch_pkg::KIND_OTHER, fetch_pkg::KIND_CALL,
		fetch_pkg::KIND_OTHER, fetch_pkg::KIND_CALL, fetch_pkg::KIND_RET,
		fetch_pkg::KIND_RET, fetch_pkg::KIND_OTHER, fetch_pkg::KIND_CALL,
		fetch_pkg::KIND_RET, fetch_pkg::KIND_RET
	};

	// ========================================================================
	// DUT signals
	// ========================================================================
	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	logic in_ready;
	fetch_pkg::pc_address_t in_pc;
	fetch_pkg::instruction_t in_insn;
	logic out_valid;
	logic out_ready = 1'b0;
	fetch_pkg::pc_address_t out_pc;
	fetch_pkg::insn_kind_t out_kind;
	fetch_pkg::pc_address_t out_target;

	// Scoreboard, reference stack and counters
	fetch_pkg::pc_address_t exp_pc [$];
	fetch_pkg::insn_kind_t exp_kind [$];
	fetch_pkg::pc_address_t exp_target [$];
	fetch_pkg::pc_address_t model_stack [rsb_pkg::RSB_DEPTH];
	rsb_pkg::rsb_ptr_t model_sp;
	integer seed = 32'h55935b5d;
	int stall_left = 0;
	int errors = 0;
	int sent = 0;
	int received = 0;
	int cycles = 0;

	fetch_predict_top UUT (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pc(in_pc),
		.in_insn(in_insn),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_pc(out_pc),
		.out_kind(out_kind),
		.out_target(out_target)
	);

	always #10 clk = ~clk;

	// Encodes a word of the given kind whose upper bits vary only with the pc
	function automatic fetch_pkg::instruction_t make_insn(input fetch_pkg::insn_kind_t kind,
			input fetch_pkg::pc_address_t pc);
		fetch_pkg::opcode_t op;
		begin
			case (kind)
				fetch_pkg::KIND_CALL: op = fetch_pkg::CALL_OPCODE;
				fetch_pkg::KIND_RET: op = fetch_pkg::RET_OPCODE;
				default: op = OTHER_OPCODE;
			endcase
			make_insn = {pc[32:0] ^ 33'h1A5A5A5A5, op};
		end
	endfunction

	// Queues the expected result and steps the model stack
	// Push writes below the pointer, pop moves it up, the top is at the pointer
	task automatic expect_item(input fetch_pkg::pc_address_t pc,
			input fetch_pkg::insn_kind_t kind);
		begin
			exp_pc.push_back(pc);
			exp_kind.push_back(kind);
			exp_target.push_back(model_stack[model_sp]);
			if (kind == fetch_pkg::KIND_CALL) begin
				model_sp = model_sp - rsb_pkg::rsb_ptr_t'(1);
				model_stack[model_sp] = pc + 44'(fetch_pkg::INSN_BYTES);
			end
			else if (kind == fetch_pkg::KIND_RET)
				model_sp = model_sp + rsb_pkg::rsb_ptr_t'(1);
		end
	endtask

	// Called on a falling edge and holds the word until in_ready was seen high
	task automatic send_item(input fetch_pkg::pc_address_t pc,
			input fetch_pkg::instruction_t insn);
		logic taken;
		begin
			in_valid = 1'b1;
			in_pc = pc;
			in_insn = insn;
			taken = 1'b0;
			while (!taken) begin
				taken = in_ready;
				@(negedge clk);
			end
			in_valid = 1'b0;
			sent++;
		end
	endtask

	// Compares one output transfer with the head of the scoreboard
	task automatic check_output;
		fetch_pkg::pc_address_t e_pc;
		fetch_pkg::insn_kind_t e_kind;
		fetch_pkg::pc_address_t e_target;
		begin
			if (exp_pc.size() == 0) begin
				errors++;
				$display("Output transfer with no item pending, out_pc %h", out_pc);
			end
			else begin
				e_pc = exp_pc.pop_front();
				e_kind = exp_kind.pop_front();
				e_target = exp_target.pop_front();
				if (out_pc !== e_pc) begin
					errors++;
					$display("ERR out_pc item %0d: expected %h, got %h", received, e_pc, out_pc);
				end
				if (out_kind !== e_kind) begin
					errors++;
					$display("ERR out_kind item %0d: expected %h, got %h",
						received, e_kind, out_kind);
				end
				// The target only means something for a return
				if (e_kind == fetch_pkg::KIND_RET && out_target !== e_target) begin
					errors++;
					$display("ERR out_target item %0d: expected %h, got %h",
						received, e_target, out_target);
				end
				received++;
			end
		end
	endtask

	// ========================================================================
	// Random output stall bursts and the check of each transfer
	// ========================================================================

	// A transfer happens on the next rising edge when both are high here
	always @(negedge clk) begin
		if (rst)
			out_ready = 1'b0;
		else begin
			if (stall_left > 0) begin
				out_ready = 1'b0;
				stall_left--;
			end
			else if (($random(seed) & 7) == 0) begin
				out_ready = 1'b0;
				stall_left = $random(seed) & 7;
			end
			else
				out_ready = 1'b1;
			if (out_valid && out_ready)
				check_output();
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, outputs stopped arriving (%0d of %0d received)",
				cycles, received, TOTAL_ITEMS);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_insn = '0;
		model_sp = '0;
		for (int i = 0; i < rsb_pkg::RSB_DEPTH; i++)
			model_stack[i] = rsb_pkg::RSB_RESET_ADDR;
		repeat (2) @(posedge clk);
		@(negedge clk);
		// The output side still sees reset on this falling edge
		rst <= 1'b0;

		// After reset nothing comes out and input is accepted
		repeat (4) begin
			if (out_valid !== 1'b0) begin
				errors++;
				$display("ERR out_valid after reset: expected %h, got %h", 1'b0, out_valid);
			end
			if (in_ready !== 1'b1) begin
				errors++;
				$display("ERR in_ready after reset: expected %h, got %h", 1'b1, in_ready);
			end
			@(negedge clk);
		end

		for (int i = 0; i < TABLE_ROWS; i++) begin
			expect_item(table_pc[i], table_kind[i]);
			send_item(table_pc[i], make_insn(table_kind[i], table_pc[i]));
		end

		// The nesting goes deeper than the stack so the pointer wraps and old entries
		// get overwritten
		for (int i = 0; i < NEST_DEPTH; i++) begin
			expect_item(NEST_CALL_BASE + 44'(i * 64), fetch_pkg::KIND_CALL);
			send_item(NEST_CALL_BASE + 44'(i * 64),
				make_insn(fetch_pkg::KIND_CALL, NEST_CALL_BASE + 44'(i * 64)));
		end
		for (int i = 0; i < NEST_DEPTH; i++) begin
			expect_item(NEST_RET_BASE + 44'(i * 8), fetch_pkg::KIND_RET);
			send_item(NEST_RET_BASE + 44'(i * 8),
				make_insn(fetch_pkg::KIND_RET, NEST_RET_BASE + 44'(i * 8)));
		end

		while (received < TOTAL_ITEMS)
			@(negedge clk);
		// A few more cycles so a duplicated item would still show up
		repeat (8) @(negedge clk);

		$display("Run complete: %0d errors, %0d of %0d items received", errors, received, sent);
		if (errors == 0 && received == sent)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
design/fetch_pkg.sv
design/rsb_pkg.sv
design/fetch_if.sv
design/ifetch_predecode.sv
design/fetch_queue.sv
design/return_stack.sv
design/return_predictor.sv
design/fetch_predict_top.sv
tb/fetch_predict_assertions.sv
tb/tb_fetch_predict.sv
